// ==== include/tpu_consts.svh ====
// TPU front end constants
`ifndef TPU_CONSTS_SVH
`define TPU_CONSTS_SVH

//////////////////////////////////////////////////
// Instruction word fields
`define TPU_OPCODE_W	4		// Opcode field
`define TPU_PAYLOAD_W	24		// Instruction payload

//////////////////////////////////////////////////
// Tags attached to each instruction
`define TPU_ISSUE_W		8		// Issue number from scalar unit
`define TPU_ID_W		8		// SIMT thread identifier

//////////////////////////////////////////////////
// Instruction buffer
`define TPU_BUF_DEPTH	8		// Entries, power of two

`endif

// ==== source/pkg_tpu.sv ====
// TPU front end types
`default_nettype none

`include "tpu_consts.svh"

package pkg_tpu;

	//////////////////////////////////////////////////
	// Encodings

	typedef enum logic [`TPU_OPCODE_W-1:0] {
		op_nop,
		op_add,
		op_mul,
		op_mac,						// Multiply and accumulate
		op_load,
		op_store
	} opcode_t;

	typedef enum logic [1:0] {
		fe_init,					// Idle, no packet
		fe_scalar,					// Waiting for issue number
		fe_simt,					// Waiting for thread id
		fe_instr					// Instruction stream
	} fe_state_t;

	//////////////////////////////////////////////////
	// Words and tags

	typedef struct packed {
		logic						v;
		opcode_t					opcode;
		logic [`TPU_PAYLOAD_W-1:0]	payload;
	} instr_t;

	typedef struct packed {
		logic						v;
		logic [`TPU_ISSUE_W-1:0]	number;
	} issue_no_t;

	typedef struct packed {
		logic						v;
		logic [`TPU_ID_W-1:0]		id;
	} id_t;

	// One tagged instruction as stored in the buffer
	typedef struct packed {
		logic [`TPU_ISSUE_W-1:0]	issue_no;
		logic [`TPU_ID_W-1:0]		thread_id;
		instr_t						instr;
	} buf_entry_t;

endpackage

`default_nettype wire

// ==== source/front_end.sv ====
// TPU instruction front end
`timescale 1ns/1ns
`default_nettype none

`include "tpu_consts.svh"

module front_end
	import pkg_tpu::*;
(
	input  wire logic	clock,
	input  wire logic	reset,
	input  wire logic	en_exe,				// Write without issue number
	input  wire logic	req,				// Packet in progress
	input  wire logic	full,				// Buffer full
	input  wire logic	term,				// Termination from scalar unit
	input  wire logic	nack_in,			// Refusal from back end
	input  wire instr_t	instr,
	output logic		we,					// Buffer write strobe
	output buf_entry_t	entry,				// Tagged instruction
	output logic		term_done,			// Packet finished
	output logic		nack				// To allocator
);

	logic		r_req;
	logic		r_en_exe;
	logic		r_full;
	logic		r_term;
	logic		r_nack;
	instr_t		r_instr;

	fe_state_t	state;
	issue_no_t	issue_no;
	id_t		thread_id;

	logic		set_we;

	//////////////////////////////////////////////////
	// Input registers

	always_ff @(posedge clock) begin
		if (reset) begin
			r_req		<= 1'b0;
			r_en_exe	<= 1'b0;
			r_full		<= 1'b0;
			r_term		<= 1'b0;
			r_nack		<= 1'b0;
		end else begin
			r_req		<= req;
			r_en_exe	<= en_exe;
			r_full		<= full;
			r_term		<= term;
			r_nack		<= nack_in;
		end
	end

	// Word register follows the stream only during a packet
	always_ff @(posedge clock) begin
		if (reset) begin
			r_instr		<= '0;
		end else if (r_req) begin
			r_instr		<= instr;
		end
	end

	//////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fe_init;
		end else if (!r_req) begin
			state <= fe_init;				// Packet over or idle
		end else if (r_term && state != fe_init) begin
			state <= fe_simt;				// Await a new thread id
		end else begin
			case (state)
				fe_init:	state <= fe_scalar;
				fe_scalar:	if (r_instr.v) state <= fe_simt;
				fe_simt:	if (r_instr.v) state <= fe_instr;
				default:	state <= fe_instr;
			endcase
		end
	end

	// Header capture, cleared by the scalar unit
	always_ff @(posedge clock) begin
		if (reset || r_term) begin
			issue_no	<= '0;
			thread_id	<= '0;
		end else if (r_req && r_instr.v) begin
			if (state == fe_scalar) begin
				issue_no	<= {1'b1, r_instr.payload[`TPU_ISSUE_W-1:0]};
			end
			if (state == fe_simt) begin
				thread_id	<= {1'b1, r_instr.payload[`TPU_ID_W-1:0]};
			end
		end
	end

	//////////////////////////////////////////////////
	// Write stage

	assign set_we = (state == fe_instr) & r_instr.v & r_req & ~r_term & ~r_full &
		(issue_no.v | r_en_exe);

	always_ff @(posedge clock) begin
		if (reset) begin
			we <= 1'b0;
		end else begin
			we <= set_we;
		end
	end

	always_ff @(posedge clock) begin
		if (set_we) begin
			entry.issue_no	<= issue_no.number;
			entry.thread_id	<= thread_id.id;
			entry.instr		<= r_instr;
		end
	end

	// One pulse as the sequencer drops back to idle
	always_ff @(posedge clock) begin
		if (reset) begin
			term_done <= 1'b0;
		end else begin
			term_done <= (state != fe_init) & ~r_req;
		end
	end

	assign nack = r_full | r_nack;

	//////////////////////////////////////////////////
	// Checks

	a_no_we_after_full: assert property (@(posedge clock) disable iff (reset)
		r_full |=> !we);

	a_term_done_pulse: assert property (@(posedge clock) disable iff (reset)
		term_done |=> !term_done);

endmodule

`default_nettype wire

// ==== source/instr_buffer.sv ====
// Tagged instruction FIFO
`timescale 1ns/1ns
`default_nettype none

`include "tpu_consts.svh"

module instr_buffer
	import pkg_tpu::*;
#(
	parameter int DEPTH = `TPU_BUF_DEPTH		// Power of two
) (
	input  wire logic		clock,
	input  wire logic		reset,
	input  wire logic		we,				// Push
	input  wire buf_entry_t	wdata,
	input  wire logic		pop,			// Remove head
	output buf_entry_t		head,			// Oldest entry
	output logic			full,
	output logic			empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH) + 1;

	buf_entry_t		mem [DEPTH];

	logic [AW-1:0]	wr_ptr;
	logic [AW-1:0]	rd_ptr;
	logic [CW-1:0]	count;				// Occupancy

	logic			wr_ok;
	logic			rd_ok;

	//////////////////////////////////////////////////
	// Flags

	assign full		= (count == CW'(DEPTH));
	assign empty	= (count == '0);

	assign wr_ok	= we & ~full;			// Late write on full is lost
	assign rd_ok	= pop & ~empty;

	assign head		= mem[rd_ptr];

	//////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clock) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (wr_ok) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (rd_ok) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({wr_ok, rd_ok})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Idle or both at once
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Checks

	a_no_write_on_full: assert property (@(posedge clock) disable iff (reset)
		(full && we && !pop) |=> (full && wr_ptr == $past(wr_ptr)));

	a_full_empty_excl: assert property (@(posedge clock) disable iff (reset)
		!(full && empty));

endmodule

`default_nettype wire

// ==== source/tpu_front.sv ====
// TPU instruction front end top
`timescale 1ns/1ns
`default_nettype none

module tpu_front
	import pkg_tpu::*;
(
	input  wire logic		clock,
	input  wire logic		reset,
	input  wire logic		en_exe,
	input  wire logic		req,
	input  wire logic		term,
	input  wire logic		nack_in,
	input  wire instr_t		instr,
	input  wire logic		pop,		// Back end read
	output logic			term_done,
	output logic			nack,
	output buf_entry_t		head,
	output logic			empty,
	output logic			full
);

	logic			we;
	buf_entry_t		entry;

	front_end u_front_end (
		.clock		(clock),
		.reset		(reset),
		.en_exe		(en_exe),
		.req		(req),
		.full		(full),			// Fed back from the buffer
		.term		(term),
		.nack_in	(nack_in),
		.instr		(instr),
		.we			(we),
		.entry		(entry),
		.term_done	(term_done),
		.nack		(nack)
	);

	instr_buffer u_instr_buffer (
		.clock		(clock),
		.reset		(reset),
		.we			(we),
		.wdata		(entry),
		.pop		(pop),
		.head		(head),
		.full		(full),
		.empty		(empty)
	);

endmodule

`default_nettype wire

// ==== tb/tb_tpu_front.sv ====
// TPU front end testbench
`timescale 1ns/1ns
`default_nettype none

`include "tpu_consts.svh"

module tb_tpu_front
	import pkg_tpu::*;
();

	logic		clock, reset, en_exe, req, term, nack_in, pop;
	instr_t		instr;
	logic		term_done, nack, empty, full;
	buf_entry_t	head;

	integer		seed;
	string		test_name;
	buf_entry_t	expected_q [$];			// Entries still to be popped

	tpu_front uut (
		.clock(clock), .reset(reset), .en_exe(en_exe), .req(req), .term(term),
		.nack_in(nack_in), .instr(instr), .pop(pop), .term_done(term_done),
		.nack(nack), .head(head), .empty(empty), .full(full)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		assert (actual === expected) else begin
			fail_run($sformatf("Mismatch in %s (%s): expected %b, actual %b",
				test_name, what, expected, actual));
		end
	endtask

	task automatic check_entry(input buf_entry_t expected, input buf_entry_t actual);
		assert (actual === expected) else begin
			fail_run($sformatf("Mismatch in %s (head): expected %h, actual %h",
				test_name, expected, actual));
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#10;								// Drive away from the edge
	endtask

	function automatic instr_t random_word(input logic v);
		instr_t			w;
		logic [31:0]	r;
		r = $random(seed);
		w.v = v;
		w.opcode = opcode_t'(r[26:24] % 6);
		w.payload = r[`TPU_PAYLOAD_W-1:0];
		return w;
	endfunction

	// Issue and id headers carry their tag in the low payload bits
	task automatic send_header(input logic [`TPU_ISSUE_W-1:0] value);
		instr_t w;
		w = random_word(1'b1);
		w.payload[`TPU_ISSUE_W-1:0] = value;
		instr = w;
		next_cycle();
	endtask

	task automatic send_instr(input logic [`TPU_ISSUE_W-1:0] issue,
			input logic [`TPU_ID_W-1:0] id, input logic keep);
		buf_entry_t e;
		instr = random_word(1'b1);
		e.issue_no = issue;
		e.thread_id = id;
		e.instr = instr;
		if (keep) expected_q.push_back(e);
		next_cycle();
	endtask

	task automatic send_idle();
		instr = random_word(1'b0);			// Invalid, must be ignored
		next_cycle();
	endtask

	task automatic start_packet();
		req = 1'b1;
		repeat (3) send_idle();
	endtask

	task automatic end_packet(output int cycles);
		req = 1'b0;
		cycles = 0;
		while (term_done !== 1'b1 && cycles < 20) begin
			send_idle();
			cycles++;
		end
		assert (term_done === 1'b1) else fail_run("term_done never pulsed after req fell");
		next_cycle();
	endtask

	task automatic pop_and_check();
		int n;
		n = 0;
		while (empty !== 1'b0 && n < 20) begin
			next_cycle();
			n++;
		end
		assert (empty === 1'b0) else fail_run({test_name, ": buffer stayed empty"});
		assert (expected_q.size() > 0) else fail_run({test_name, ": unexpected entry"});
		check_entry(expected_q.pop_front(), head);
		pop = 1'b1;
		next_cycle();
		pop = 1'b0;
	endtask

	task automatic drain(input int count);
		repeat (count) pop_and_check();
		repeat (4) next_cycle();
		check_bit("empty after drain", 1'b1, empty);
	endtask

	//////////////////////////////////////////////////
	// Tests

	task automatic test_reset_state();
		test_name = "reset_state";
		check_bit("empty", 1'b1, empty);
		check_bit("full", 1'b0, full);
		check_bit("term_done", 1'b0, term_done);
		check_bit("nack", 1'b0, nack);
	endtask

	task automatic test_tagging();
		test_name = "tagging";
		start_packet();
		send_header(8'hc3);					// Issue number
		send_idle();
		send_header(8'h4e);					// Thread id
		for (int i = 0; i < 5; i++) begin
			send_instr(8'hc3, 8'h4e, 1'b1);
			if (i % 2 == 0) send_idle();
		end
		drain(5);
	endtask

	task automatic test_termination();
		int cycles;
		test_name = "termination";
		end_packet(cycles);
		assert (cycles == 2) else begin
			fail_run($sformatf("Mismatch in %s (cycles to term_done): expected 2, actual %0d",
				test_name, cycles));
		end
		check_bit("term_done one cycle only", 1'b0, term_done);
	endtask

	task automatic test_term_pulse();
		int cycles;
		test_name = "term_pulse";
		en_exe = 1'b1;
		start_packet();
		send_header(8'h5a);
		send_header(8'h21);
		repeat (2) send_instr(8'h5a, 8'h21, 1'b1);
		send_idle();
		drain(2);
		term = 1'b1;
		send_idle();
		term = 1'b0;
		repeat (2) send_idle();
		send_header(8'h3c);					// New thread id, no issue number
		repeat (3) send_instr(8'h00, 8'h3c, 1'b1);
		send_idle();
		drain(3);
		end_packet(cycles);
		en_exe = 1'b0;
	endtask

	task automatic test_back_pressure();
		test_name = "back_pressure";
		start_packet();
		send_header(8'h77);
		send_header(8'h0f);
		for (int i = 0; i < `TPU_BUF_DEPTH + 4; i++) begin
			send_instr(8'h77, 8'h0f, i < `TPU_BUF_DEPTH);	// Overflow words are lost
		end
		repeat (3) send_idle();				// Two words still in flight
		check_bit("full", 1'b1, full);
		check_bit("nack", 1'b1, nack);
		drain(`TPU_BUF_DEPTH);
	endtask

	task automatic test_backend_nack();
		int n;
		test_name = "backend_nack";
		n = 0;
		while (nack !== 1'b0 && n < 20) begin
			send_idle();
			n++;
		end
		check_bit("nack idle", 1'b0, nack);
		nack_in = 1'b1;
		check_bit("nack same cycle", 1'b0, nack);
		send_idle();
		check_bit("nack one cycle later", 1'b1, nack);
		nack_in = 1'b0;
		send_idle();
		check_bit("nack released", 1'b0, nack);
		end_packet(n);
	endtask

	initial begin
		seed = 32'he7f93152;
		reset = 1'b1;
		en_exe = 1'b0;
		req = 1'b0;
		term = 1'b0;
		nack_in = 1'b0;
		pop = 1'b0;
		instr = '0;
		repeat (16) @(posedge clock);
		#10;
		reset = 1'b0;
		next_cycle();
		test_reset_state();
		test_tagging();
		test_termination();
		test_term_pulse();
		test_back_pressure();
		test_backend_nack();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tpu_front.f ====
+incdir+include
source/pkg_tpu.sv
source/front_end.sv
source/instr_buffer.sv
source/tpu_front.sv
tb/tb_tpu_front.sv

// ==== Makefile ====
# Verilator build of the TPU instruction front end

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, passes on the pass message"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_tpu_front -Mdir obj_dir -f tpu_front.f
	./obj_dir/Vtb_tpu_front | tee /dev/stderr | grep "Regression passed" > /dev/null

clean:
	rm -rf obj_dir
